//--- files.f
+incdir+include
logic/chbuf_pkg.sv
logic/space_tracker.sv
logic/channel_fifo.sv
logic/latency_bridge.sv
logic/channel_unit.sv
logic/chbuf_controller.sv
verif/chbuf_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the staging buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module chbuf_tb -Mdir obj_dir
./obj_dir/Vchbuf_tb > sim.log
cat sim.log

# Verdict is taken from the simulation log
if grep -q "Testbench passed" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi

//--- verif/chbuf_tb.sv
/*
 * Testbench for the multi-channel staging buffer
 *   Step table of allocate, write, reserve, read and bad-ID operations
 *   Per-channel scoreboard queues and models of the credit counters
 *   Galois LFSR write data, bounded waits, closing error count
 */

`timescale 1ns/100ps

`include "chbuf_defs.svh"

module chbuf_tb
        import chbuf_pkg::*;
();

        localparam int NC         = `CHBUF_NUM_CH;
        localparam int DEPTH      = `CHBUF_DEPTH;
        localparam int WAIT_LIMIT = 64;         // Cycles per wait
        localparam int NUM_ROWS   = 15;

        typedef enum logic [2:0] {OP_ALLOC, OP_WRITE, OP_RESERVE, OP_READ, OP_BADID} op_e;

        typedef struct packed {
                op_e        op;
                logic [7:0] ch;
                logic [7:0] size;
                logic       exp_ok;             // Writes accepted, 0 means ready must stay low
        } step_s;

        logic           clk;
        logic           arst_n;
        alloc_req_s     alloc;
        cnt_t  [NC-1:0] space_free;
        wr_beat_s       wr;
        logic           wr_ready;
        logic  [NC-1:0] drain_req;
        size_t [NC-1:0] drain_size;
        cnt_t  [NC-1:0] data_avail;
        logic  [NC-1:0] rd_valid;
        rd_sel_s        rd;
        beat_t          rd_data;

        step_s       steps [NUM_ROWS];
        beat_t       sb [NC][$];                // Expected beats per channel
        int          m_space [NC];              // Model of space_free
        int          m_credit [NC];
        int          m_avail [NC];              // Model of data_avail
        logic [15:0] lfsr;
        int          errors;
        int          checks;
        logic        timed_out;

        chbuf_controller UUT (
                .clk        (clk),
                .arst_n     (arst_n),
                .alloc      (alloc),
                .space_free (space_free),
                .wr         (wr),
                .wr_ready   (wr_ready),
                .drain_req  (drain_req),
                .drain_size (drain_size),
                .data_avail (data_avail),
                .rd_valid   (rd_valid),
                .rd         (rd),
                .rd_data    (rd_data)
        );

        always #50 clk = ~clk;                  // 100 ns period

        //==========================================================================
        // Data source and checks
        //==========================================================================
        // Galois step, taps x^16 + x^14 + x^13 + x^11 + 1
        function automatic logic [15:0] lfsr_step(input logic [15:0] s);
                logic lsb;
                lsb = s[0];
                s   = s >> 1;
                if (lsb)
                        s = s ^ 16'hB400;
                return s;
        endfunction

        function automatic beat_t next_beat();
                beat_t d;
                for (int i = 0; i < `CHBUF_DATA_W; i++) begin
                        lfsr = lfsr_step(lfsr);   // One step per bit taken
                        d[i] = lfsr[0];
                end
                return d;
        endfunction

        task automatic flag_timeout(input string what);
                $display("Timeout while waiting for %s", what);
                errors++;
                timed_out = 1'b1;
        endtask

        // All channels, so isolation is covered too
        task automatic check_counters();
                for (int i = 0; i < NC; i++) begin
                        checks++;
                        if (space_free[i] !== cnt_t'(m_space[i])) begin
                                $display("[ERROR] space_free[%0d] expected 0x%0h got 0x%0h",
                                         i, m_space[i], space_free[i]);
                                errors++;
                        end
                        if (data_avail[i] !== cnt_t'(m_avail[i])) begin
                                $display("[ERROR] data_avail[%0d] expected 0x%0h got 0x%0h",
                                         i, m_avail[i], data_avail[i]);
                                errors++;
                        end
                end
        endtask

        task automatic check_ready_low(input int ch);
                checks++;
                if (wr_ready !== 1'b0) begin
                        $display("[ERROR] wr_ready (ch %0d) expected 0x0 got 0x%0h", ch, wr_ready);
                        errors++;
                end
        endtask

        //==========================================================================
        // Operations, each starts and ends 1 ns after a rising edge
        //==========================================================================
        task automatic do_alloc(input int ch, input int size);
                if (size > m_space[ch]) begin
                        $display("Allocation of %0d beats on channel %0d exceeds free space",
                                 size, ch);
                        errors++;
                        return;
                end
                alloc = '{req: 1'b1, id: chan_id_t'(ch), size: size_t'(size)};
                @(posedge clk);
                #1;
                alloc.req = 1'b0;
                m_space[ch]  -= size;
                m_credit[ch] += size;
                check_counters();
        endtask

        task automatic do_write(input int ch, input int n, input logic exp_ok);
                int    sent;
                int    waits;
                beat_t d;
                sent     = 0;
                waits    = 0;
                wr.id    = chan_id_t'(ch);
                wr.valid = 1'b0;
                @(posedge clk);
                #1;
                if (!exp_ok) begin
                        check_ready_low(ch);    // No credits held
                        return;
                end
                while (sent < n && !timed_out) begin
                        if (wr_ready === 1'b1) begin
                                d        = next_beat();
                                wr.valid = 1'b1;        // Transfers on the coming edge
                                wr.data  = d;
                                sb[ch].push_back(d);
                                m_credit[ch]--;
                                m_avail[ch]++;
                                sent++;
                                waits = 0;
                        end else begin
                                wr.valid = 1'b0;
                                waits++;
                                if (waits > WAIT_LIMIT)
                                        flag_timeout("wr_ready");
                        end
                        @(posedge clk);
                        #1;
                end
                wr.valid = 1'b0;
                if (m_credit[ch] == 0)
                        check_ready_low(ch);    // Credits used up
                check_counters();
        endtask

        task automatic do_reserve(input int ch, input int size);
                if (size > m_avail[ch]) begin
                        $display("Reservation of %0d beats on channel %0d exceeds available data",
                                 size, ch);
                        errors++;
                        return;
                end
                drain_req[ch]  = 1'b1;
                drain_size[ch] = size_t'(size);
                @(posedge clk);
                #1;
                drain_req[ch] = 1'b0;
                m_avail[ch] -= size;
                check_counters();
        endtask

        task automatic do_read(input int ch, input int n);
                int    waits;
                beat_t exp_d;
                rd = '{drain: 1'b0, id: chan_id_t'(ch)};
                @(posedge clk);
                #1;
                for (int b = 0; b < n; b++) begin
                        waits = 0;
                        while (rd_valid[ch] !== 1'b1 && !timed_out) begin
                                @(posedge clk);
                                #1;
                                waits++;
                                if (waits > WAIT_LIMIT)
                                        flag_timeout("rd_valid");
                        end
                        if (timed_out)
                                return;
                        if (sb[ch].size() == 0) begin
                                $display("Channel %0d holds a beat that was never written", ch);
                                errors++;
                                return;
                        end
                        exp_d = sb[ch].pop_front();
                        checks++;
                        if (rd_data !== exp_d) begin
                                $display("[ERROR] rd_data (ch %0d beat %0d) expected 0x%08h got 0x%08h",
                                         ch, b, exp_d, rd_data);
                                errors++;
                        end
                        rd.drain = 1'b1;        // Pop on the coming edge
                        @(posedge clk);
                        #1;
                        rd.drain = 1'b0;
                        m_space[ch]++;
                        checks++;
                        if (rd_valid[ch] !== 1'b0) begin  // Bridge holds one beat only
                                $display("[ERROR] rd_valid[%0d] expected 0x0 got 0x%0h",
                                         ch, rd_valid[ch]);
                                errors++;
                        end
                        check_counters();
                end
        endtask

        // Needs an ID code beyond the last channel
        task automatic do_badid();
                if ((1 << `CHBUF_ID_W) <= NC) begin
                        $display("Bad-ID step skipped, every ID code names a channel");
                        return;
                end
                alloc = '{req: 1'b1, id: chan_id_t'(NC), size: 8'd1};
                wr    = '{valid: 1'b1, id: chan_id_t'(NC), data: next_beat()};
                rd    = '{drain: 1'b1, id: chan_id_t'(NC)};
                @(posedge clk);
                #1;
                check_ready_low(NC);
                checks++;
                if (rd_data !== '0) begin
                        $display("[ERROR] rd_data (bad ID) expected 0x0 got 0x%08h", rd_data);
                        errors++;
                end
                alloc.req = 1'b0;
                wr.valid  = 1'b0;
                rd.drain  = 1'b0;
                check_counters();               // Nothing may have moved
        endtask

        //==========================================================================
        // Step table and main sequence
        //==========================================================================
        initial begin
                steps[0]  = '{OP_ALLOC,   8'd0, 8'd4,  1'b1};
                steps[1]  = '{OP_ALLOC,   8'd1, 8'd3,  1'b1};
                steps[2]  = '{OP_WRITE,   8'd3, 8'd0,  1'b0};   // Never allocated
                steps[3]  = '{OP_WRITE,   8'd0, 8'd2,  1'b1};
                steps[4]  = '{OP_WRITE,   8'd1, 8'd3,  1'b1};   // Interleaved bursts
                steps[5]  = '{OP_WRITE,   8'd0, 8'd2,  1'b1};
                steps[6]  = '{OP_RESERVE, 8'd0, 8'd4,  1'b1};
                steps[7]  = '{OP_RESERVE, 8'd1, 8'd3,  1'b1};
                steps[8]  = '{OP_READ,    8'd1, 8'd3,  1'b1};
                steps[9]  = '{OP_READ,    8'd0, 8'd4,  1'b1};
                steps[10] = '{OP_ALLOC,   8'd2, 8'(DEPTH), 1'b1};
                steps[11] = '{OP_WRITE,   8'd2, 8'(DEPTH), 1'b1}; // Consumer idle, FIFO fills
                steps[12] = '{OP_RESERVE, 8'd2, 8'(DEPTH), 1'b1};
                steps[13] = '{OP_READ,    8'd2, 8'(DEPTH), 1'b1};
                steps[14] = '{OP_BADID,   8'd0, 8'd0,  1'b0};

                clk        = 1'b0;
                arst_n     = 1'b0;
                alloc      = '0;
                wr         = '0;
                rd         = '0;
                drain_req  = '0;
                drain_size = '0;
                lfsr       = 16'd18;
                errors     = 0;
                checks     = 0;
                timed_out  = 1'b0;
                for (int i = 0; i < NC; i++) begin
                        m_space[i]  = DEPTH;
                        m_credit[i] = 0;
                        m_avail[i]  = 0;
                end

                repeat (5) @(posedge clk);
                #1;
                arst_n = 1'b1;
                @(posedge clk);
                #1;
                check_counters();
                check_ready_low(0);
                checks++;
                if (rd_valid !== '0) begin
                        $display("[ERROR] rd_valid expected 0x0 got 0x%0h", rd_valid);
                        errors++;
                end

                for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
                        case (steps[r].op)
                                OP_ALLOC:   do_alloc(steps[r].ch, steps[r].size);
                                OP_WRITE:   do_write(steps[r].ch, steps[r].size, steps[r].exp_ok);
                                OP_RESERVE: do_reserve(steps[r].ch, steps[r].size);
                                OP_READ:    do_read(steps[r].ch, steps[r].size);
                                default:    do_badid();
                        endcase
                end

                $display("Checks run: %0d, errors: %0d", checks, errors);
                if (errors == 0 && !timed_out)
                        $display("Testbench passed");
                else
                        $display("Testbench failed");
                $finish;
        end

endmodule

//--- logic/chbuf_controller.sv
/*
 * Multi-channel staging buffer, top level
 *   ID decode of allocation, write and drain into per-channel strobes
 *   Ready and read data multiplexed back by ID, out-of-range IDs rejected
 *   One channel unit per channel
 */

`timescale 1ns/100ps

`include "chbuf_defs.svh"

module chbuf_controller
        import chbuf_pkg::*;
(
        input  logic                          clk,
        input  logic                          arst_n,
        // Allocation, single request steered by ID
        input  alloc_req_s                    alloc,
        output cnt_t [`CHBUF_NUM_CH-1:0]      space_free,
        // Producer write bus
        input  wr_beat_s                      wr,
        output logic                          wr_ready,   // From selected channel
        // Drain reservation, one lane per channel
        input  logic [`CHBUF_NUM_CH-1:0]      drain_req,
        input  size_t [`CHBUF_NUM_CH-1:0]     drain_size,
        output cnt_t [`CHBUF_NUM_CH-1:0]      data_avail,
        // Consumer read bus
        output logic [`CHBUF_NUM_CH-1:0]      rd_valid,
        input  rd_sel_s                       rd,
        output beat_t                         rd_data
);

        localparam int NC = `CHBUF_NUM_CH;

        logic  [NC-1:0] alloc_hit;      // One-hot allocation strobe
        logic  [NC-1:0] wr_hit;
        logic  [NC-1:0] rd_hit;
        logic  [NC-1:0] wr_ready_ch;
        beat_t [NC-1:0] rd_data_ch;

        // True when the ID names an existing channel
        function automatic logic id_ok(input chan_id_t id);
                return int'(id) < NC;
        endfunction

        //==========================================================================
        // ID decode
        //==========================================================================
        always_comb begin
                alloc_hit = '0;
                wr_hit    = '0;
                rd_hit    = '0;
                if (alloc.req && id_ok(alloc.id))
                        alloc_hit[alloc.id] = 1'b1;
                if (wr.valid && id_ok(wr.id))
                        wr_hit[wr.id] = 1'b1;
                if (rd.drain && id_ok(rd.id))
                        rd_hit[rd.id] = 1'b1;   // Bridge also gates on its own valid
        end

        // Return path, bad IDs see not-ready and zero data
        always_comb begin
                wr_ready = 1'b0;
                rd_data  = '0;
                if (id_ok(wr.id))
                        wr_ready = wr_ready_ch[wr.id];
                if (id_ok(rd.id))
                        rd_data = rd_data_ch[rd.id];
        end

        //==========================================================================
        // Channel array
        //==========================================================================
        for (genvar i = 0; i < NC; i++) begin : gen_ch
                channel_unit u_unit (
                        .clk        (clk),
                        .arst_n     (arst_n),
                        .alloc_req  (alloc_hit[i]),
                        .alloc_size (alloc.size),       // Shared by all channels
                        .space_free (space_free[i]),
                        .wr_valid   (wr_hit[i]),
                        .wr_data    (wr.data),          // Shared, only one pushes
                        .wr_ready   (wr_ready_ch[i]),
                        .drain_req  (drain_req[i]),
                        .drain_size (drain_size[i]),
                        .data_avail (data_avail[i]),
                        .rd_valid   (rd_valid[i]),
                        .rd_drain   (rd_hit[i]),
                        .rd_data    (rd_data_ch[i])
                );
        end

endmodule

//--- logic/channel_unit.sv
/*
 * One channel of the staging buffer
 *   Space tracker, FIFO and latency bridge
 *   Forms the push and pop strobes from the two handshakes
 */

`timescale 1ns/100ps

module channel_unit
        import chbuf_pkg::*;
(
        input  logic  clk,
        input  logic  arst_n,
        // Allocation
        input  logic  alloc_req,
        input  size_t alloc_size,
        output cnt_t  space_free,
        // Producer side
        input  logic  wr_valid,
        input  beat_t wr_data,
        output logic  wr_ready,
        // Drain reservation
        input  logic  drain_req,
        input  size_t drain_size,
        output cnt_t  data_avail,
        // Consumer side
        output logic  rd_valid,
        input  logic  rd_drain,
        output beat_t rd_data
);

        logic  push;                    // Write beat accepted
        logic  pop;                     // Held beat handed out
        logic  fifo_empty;
        logic  fetch;
        beat_t fetch_data;

        assign push = wr_valid & wr_ready;
        assign pop  = rd_drain & rd_valid;

        // Credit and occupancy counters
        space_tracker u_tracker (
                .clk        (clk),
                .arst_n     (arst_n),
                .alloc_req  (alloc_req),
                .alloc_size (alloc_size),
                .push       (push),
                .pop        (pop),
                .drain_req  (drain_req),
                .drain_size (drain_size),
                .space_free (space_free),
                .credit_ok  (wr_ready),         // Ready while credits remain
                .data_avail (data_avail)
        );

        channel_fifo u_fifo (
                .clk        (clk),
                .arst_n     (arst_n),
                .push       (push),
                .push_data  (wr_data),
                .fetch      (fetch),
                .fetch_data (fetch_data),
                .empty      (fifo_empty)
        );

        latency_bridge u_bridge (
                .clk        (clk),
                .arst_n     (arst_n),
                .fifo_empty (fifo_empty),
                .fetch      (fetch),
                .fetch_data (fetch_data),
                .out_valid  (rd_valid),
                .out_pop    (pop),
                .out_data   (rd_data)
        );

endmodule

//--- logic/latency_bridge.sv
/*
 * Read latency bridge between a channel FIFO and the consumer
 *   Issues a FIFO fetch, waits one edge for the registered data
 *   Holds a single beat in an output register with valid/pop handshake
 */

`timescale 1ns/100ps

module latency_bridge
        import chbuf_pkg::*;
(
        input  logic  clk,
        input  logic  arst_n,
        input  logic  fifo_empty,
        output logic  fetch,            // FIFO read strobe
        input  beat_t fetch_data,       // Valid one edge after fetch
        output logic  out_valid,
        input  logic  out_pop,          // Consumer takes the held beat
        output beat_t out_data
);

        bridge_state_e state;
        bridge_state_e state_nxt;

        //==========================================================================
        // State machine
        //==========================================================================
        always_comb begin
                state_nxt = state;
                case (state)
                        BR_EMPTY: begin
                                if (!fifo_empty)
                                        state_nxt = BR_FETCH;   // Read issued this cycle
                        end
                        BR_FETCH: begin
                                state_nxt = BR_FULL;            // Data lands this edge
                        end
                        BR_FULL: begin
                                if (out_pop)
                                        state_nxt = BR_EMPTY;
                        end
                        default: begin
                                state_nxt = BR_EMPTY;
                        end
                endcase
        end

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n)
                        state <= BR_EMPTY;
                else
                        state <= state_nxt;
        end

        // Fetch only when the output register is free
        assign fetch = (state == BR_EMPTY) && !fifo_empty;

        // Capture the FIFO read data the edge after the fetch
        always_ff @(posedge clk) begin
                if (state == BR_FETCH)
                        out_data <= fetch_data;
        end

        assign out_valid = (state == BR_FULL);

        // Pop comes from the top-level decode, must only hit a held beat
        a_pop_when_full: assert property (@(posedge clk) disable iff (!arst_n)
                out_pop |-> (state == BR_FULL))
                else $error("bridge popped while not holding a beat");

endmodule

//--- logic/channel_fifo.sv
/*
 * Synchronous single-clock FIFO for one channel
 *   Circular buffer with wrap-around pointers and occupancy count
 *   Registered read port, data valid one edge after fetch
 */

`timescale 1ns/100ps

`include "chbuf_defs.svh"

module channel_fifo
        import chbuf_pkg::*;
#(
        parameter int DEPTH = `CHBUF_DEPTH
) (
        input  logic  clk,
        input  logic  arst_n,
        input  logic  push,
        input  beat_t push_data,
        input  logic  fetch,            // Read request, data follows next edge
        output beat_t fetch_data,
        output logic  empty
);

        localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;    // Pointer width
        localparam int OW = $clog2(DEPTH + 1);                  // Occupancy width

        beat_t           mem [DEPTH];
        logic [AW-1:0]   wr_ptr;
        logic [AW-1:0]   rd_ptr;
        logic [OW-1:0]   count;
        logic            full;

        assign empty = (count == '0);
        assign full  = (count == OW'(DEPTH));

        //==========================================================================
        // Storage and registered read
        //==========================================================================
        always_ff @(posedge clk) begin
                if (push)
                        mem[wr_ptr] <= push_data;
                if (fetch)
                        fetch_data <= mem[rd_ptr];      // Held until the next fetch
        end

        // Pointers and occupancy
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (push)
                                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                        if (fetch)
                                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                        case ({push, fetch})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;        // Both or neither
                        endcase
                end
        end

        // Overflow can only come from a credit leak in the tracker
        a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
                push |-> !full)
                else $error("push into full FIFO");

        a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n)
                fetch |-> !empty)
                else $error("fetch from empty FIFO");

endmodule

//--- logic/space_tracker.sv
/*
 * Per-channel credit bookkeeping
 *   space_free  : FIFO slots not yet promised to the producer
 *   credits     : allocated slots still waiting for a write beat
 *   data_avail  : written beats not yet reserved by the consumer
 * Concurrent checks on the producer and consumer request rules
 */

`timescale 1ns/100ps

`include "chbuf_defs.svh"

module space_tracker
        import chbuf_pkg::*;
(
        input  logic  clk,
        input  logic  arst_n,
        input  logic  alloc_req,        // Reserve alloc_size slots
        input  size_t alloc_size,
        input  logic  push,             // Beat written to the FIFO
        input  logic  pop,              // Beat taken from the bridge
        input  logic  drain_req,        // Consumer reserves drain_size beats
        input  size_t drain_size,
        output cnt_t  space_free,
        output logic  credit_ok,        // At least one write credit left
        output cnt_t  data_avail
);

        cnt_t credits;                  // Outstanding write credits
        cnt_t alloc_amt;                // Allocation this cycle, zero when idle
        cnt_t drain_amt;

        // Sizes never exceed the depth, so the low bits carry the whole value
        assign alloc_amt = alloc_req ? cnt_t'(alloc_size) : '0;
        assign drain_amt = drain_req ? cnt_t'(drain_size) : '0;

        //==========================================================================
        // Counters, all three move on the same edge
        //==========================================================================
        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                        space_free <= cnt_t'(`CHBUF_DEPTH);     // Whole FIFO free
                        credits    <= '0;
                        data_avail <= '0;
                end else begin
                        // Pop hands a slot back, allocation takes slots away
                        space_free <= space_free - alloc_amt + cnt_t'(pop);
                        // Credits granted by allocation, spent by writes
                        credits    <= credits + alloc_amt - cnt_t'(push);
                        // Written beats become visible, reservations hide them
                        data_avail <= data_avail + cnt_t'(push) - drain_amt;
                end
        end

        assign credit_ok = (credits != '0);   // Drives write ready upstream

        //==========================================================================
        // Request rules from the controller interface
        //==========================================================================
        a_alloc_fits: assert property (@(posedge clk) disable iff (!arst_n)
                alloc_req |-> (alloc_size <= size_t'(space_free)))
                else $error("allocation larger than free space");

        a_push_has_credit: assert property (@(posedge clk) disable iff (!arst_n)
                push |-> credit_ok)
                else $error("write accepted without a credit");

        a_drain_fits: assert property (@(posedge clk) disable iff (!arst_n)
                drain_req |-> (drain_size <= size_t'(data_avail)))
                else $error("drain reservation larger than available data");

endmodule

//--- logic/chbuf_pkg.sv
/*
 * Shared types for the channel staging buffer
 *   Scalar types for channel ID, beat, count and burst size
 *   Request structs for allocation, write and read select
 *   Latency bridge state encoding
 */

`include "chbuf_defs.svh"

package chbuf_pkg;

        //==========================================================================
        // Scalar types
        //==========================================================================
        typedef logic [`CHBUF_ID_W-1:0]   chan_id_t;   // Channel select on shared buses
        typedef logic [`CHBUF_DATA_W-1:0] beat_t;      // One payload beat
        typedef logic [`CHBUF_CNT_W-1:0]  cnt_t;       // 0 .. depth inclusive
        typedef logic [7:0]               size_t;      // Burst length in beats

        //==========================================================================
        // Bus bundles
        //==========================================================================
        typedef struct packed {
                logic     req;          // One-cycle allocation strobe
                chan_id_t id;           // Target channel
                size_t    size;         // Beats to reserve
        } alloc_req_s;

        typedef struct packed {
                logic     valid;        // Producer has a beat
                chan_id_t id;
                beat_t    data;
        } wr_beat_s;

        typedef struct packed {
                logic     drain;        // Consumer takes the beat this cycle
                chan_id_t id;
        } rd_sel_s;

        // Output register of the latency bridge
        typedef enum logic [1:0] {
                BR_EMPTY = 2'd0,        // Nothing held, may fetch
                BR_FETCH = 2'd1,        // FIFO read in flight
                BR_FULL  = 2'd2         // Beat presented to consumer
        } bridge_state_e;

endpackage

//--- include/chbuf_defs.svh
/*
 * Build-time sizing for the channel staging buffer
 *   Channel count, beat width and per-channel FIFO depth
 *   Derived widths for channel IDs and beat counts
 */

`ifndef CHBUF_DEFS_SVH
`define CHBUF_DEFS_SVH

// Number of independent channels
`define CHBUF_NUM_CH  4

// Width of one data beat in bits
`define CHBUF_DATA_W  32

// Beats held by each channel FIFO
`define CHBUF_DEPTH   16

// ID needs at least one bit, even for a single channel
`define CHBUF_ID_W    ((`CHBUF_NUM_CH > 1) ? $clog2(`CHBUF_NUM_CH) : 1)

// Counts run from zero up to and including the depth
`define CHBUF_CNT_W   ($clog2(`CHBUF_DEPTH) + 1)

`endif
